// File: include/l2c_settings.svh
`ifndef L2C_SETTINGS_SVH
`define L2C_SETTINGS_SVH

// Byte address width of client and memory ports
`define L2C_ADDR_W 32

// Width of one burst beat
`define L2C_DATA_W 64

// Associativity and number of sets
`define L2C_WAYS 4
`define L2C_SETS 32

// One line is one full memory burst
`define L2C_LINE_BEATS 16

// Replacement LFSR start value, must not be zero
`define L2C_LFSR_SEED 16'hace1

`endif

// File: design/l2c_pkg.sv
`include "l2c_settings.svh"

package l2c_pkg;

	// Byte offset inside one beat
	localparam int BYTE_W = $clog2(`L2C_DATA_W / 8);
	// Beat index inside one line
	localparam int BEAT_W = $clog2(`L2C_LINE_BEATS);
	// Byte offset inside one line
	localparam int OFFSET_W = BYTE_W + BEAT_W;
	localparam int SET_W = $clog2(`L2C_SETS);
	localparam int TAG_W = `L2C_ADDR_W - SET_W - OFFSET_W;
	// Binary way index, used for the random victim
	localparam int WAY_W = $clog2(`L2C_WAYS);

	// Controller states
	typedef enum logic [2:0] {
		state_free,
		state_check_tag,
		state_refill,
		state_resp_inst,
		state_resp_data,
		state_fence
	} l2c_state_e;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [SET_W-1:0] set_t;
	typedef logic [BEAT_W-1:0] beat_t;
	// One hot, one bit per way
	typedef logic [`L2C_WAYS-1:0] way_mask_t;

endpackage

// File: design/data_store.sv
`include "l2c_settings.svh"

module data_store (
	input  logic clk,
	input  l2c_pkg::set_t set,
	input  l2c_pkg::way_mask_t way,
	input  logic fill_en,
	input  l2c_pkg::beat_t fill_beat,
	input  l2c_pkg::beat_t read_beat,
	input  logic [`L2C_DATA_W-1:0] fill_data,
	output logic [`L2C_DATA_W-1:0] read_data
);

	logic [`L2C_DATA_W-1:0] mem [`L2C_WAYS][`L2C_SETS][`L2C_LINE_BEATS];

	// One beat per fill, into the selected way
	always_ff @(posedge clk) begin
		if (fill_en) begin
			for (int w = 0; w < `L2C_WAYS; w++) begin
				if (way[w])
					mem[w][set][fill_beat] <= fill_data;
			end
		end
	end

	// One-hot way mux
	always_comb begin
		read_data = '0;
		for (int w = 0; w < `L2C_WAYS; w++) begin
			if (way[w])
				read_data = read_data | mem[w][set][read_beat];
		end
	end

endmodule

// File: design/tag_store.sv
`include "l2c_settings.svh"

module tag_store (
	input  logic clk,
	input  logic reset,
	input  logic [`L2C_ADDR_W-1:0] req_addr,
	input  logic allocate,
	input  logic fence_clear,
	output logic hit,
	output l2c_pkg::way_mask_t hit_way
);

	l2c_pkg::tag_t tags [`L2C_WAYS][`L2C_SETS];
	logic [`L2C_SETS-1:0] valid [`L2C_WAYS];

	l2c_pkg::set_t set_idx;
	l2c_pkg::tag_t req_tag;
	l2c_pkg::way_mask_t victim;
	logic found_free;
	logic [15:0] lfsr;

	// Split the request address
	assign set_idx = req_addr[l2c_pkg::OFFSET_W +: l2c_pkg::SET_W];
	assign req_tag = req_addr[`L2C_ADDR_W-1 -: l2c_pkg::TAG_W];

	// Compare all ways of the set at once
	always_comb begin
		for (int w = 0; w < `L2C_WAYS; w++) begin
			hit_way[w] = valid[w][set_idx] & (tags[w][set_idx] == req_tag);
		end
	end

	assign hit = |hit_way;

	// Lowest invalid way, else a random one
	always_comb begin
		victim = '0;
		found_free = 1'b0;
		for (int w = 0; w < `L2C_WAYS; w++) begin
			if (!valid[w][set_idx] && !found_free) begin
				victim[w] = 1'b1;
				found_free = 1'b1;
			end
		end
		if (!found_free)
			victim = l2c_pkg::way_mask_t'(1) << lfsr[l2c_pkg::WAY_W-1:0];
	end

	// Free running, taps 16 14 13 11
	always_ff @(posedge clk) begin
		if (reset)
			lfsr <= `L2C_LFSR_SEED;
		else
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
	end

	// Valid bits, fence clears the whole array
	always_ff @(posedge clk) begin
		if (reset || fence_clear) begin
			for (int w = 0; w < `L2C_WAYS; w++)
				valid[w] <= '0;
		end else if (allocate) begin
			for (int w = 0; w < `L2C_WAYS; w++) begin
				if (victim[w])
					valid[w][set_idx] <= 1'b1;
			end
		end
	end

	// Tag write into the victim
	always_ff @(posedge clk) begin
		if (allocate) begin
			for (int w = 0; w < `L2C_WAYS; w++) begin
				if (victim[w])
					tags[w][set_idx] <= req_tag;
			end
		end
	end

endmodule

// File: design/mem_refill.sv
`include "l2c_settings.svh"

module mem_refill (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [`L2C_ADDR_W-1:0] req_addr,
	input  logic mem_arready,
	input  logic mem_rvalid,
	input  logic [`L2C_DATA_W-1:0] mem_rdata,
	input  logic mem_rlast,
	output logic mem_arvalid,
	output logic [`L2C_ADDR_W-1:0] mem_araddr,
	output logic [7:0] mem_arlen,
	output logic mem_rready,
	output logic fill_en,
	output l2c_pkg::beat_t fill_beat,
	output logic [`L2C_DATA_W-1:0] fill_data,
	output logic done
);

	// Whole line, always from beat zero
	assign mem_araddr = {req_addr[`L2C_ADDR_W-1:l2c_pkg::OFFSET_W], {l2c_pkg::OFFSET_W{1'b0}}};
	assign mem_arlen = 8'(`L2C_LINE_BEATS - 1);

	assign fill_en = mem_rvalid & mem_rready;
	assign fill_data = mem_rdata;
	// Stalls on the memory side just push this out
	assign done = fill_en & mem_rlast;

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_arvalid <= 1'b0;
			mem_rready <= 1'b0;
		end else begin
			// Address held until memory takes it
			if (start)
				mem_arvalid <= 1'b1;
			else if (mem_arready)
				mem_arvalid <= 1'b0;
			// Accept data from address handshake to last beat
			if (mem_arvalid & mem_arready)
				mem_rready <= 1'b1;
			else if (done)
				mem_rready <= 1'b0;
		end
	end

	// Beat counter for fill writes
	always_ff @(posedge clk) begin
		if (start)
			fill_beat <= '0;
		else if (fill_en)
			fill_beat <= fill_beat + 1'b1;
	end

endmodule

// File: design/l1_read_port.sv
`include "l2c_settings.svh"

module l1_read_port (
	input  logic clk,
	input  logic reset,
	input  logic grant,
	input  logic arvalid,
	input  logic [`L2C_ADDR_W-1:0] araddr,
	input  logic [7:0] arlen,
	input  logic rready,
	input  logic [`L2C_DATA_W-1:0] read_data,
	output logic arready,
	output logic rvalid,
	output logic [`L2C_DATA_W-1:0] rdata,
	output logic rlast,
	output l2c_pkg::beat_t beat,
	output logic done
);

	// Beats still to send after the current one
	logic [7:0] remain;
	logic xfer;

	assign xfer = rvalid & rready;
	assign rlast = rvalid & (remain == 8'd0);
	assign done = xfer & rlast;

	// Store output stays put while beat is held, so no copy is kept
	assign rdata = read_data;

	// Handshake flags
	always_ff @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			// Single cycle accept, one cycle after grant
			arready <= grant & arvalid;
			// First beat the cycle after accept
			if (arready)
				rvalid <= 1'b1;
			else if (done)
				rvalid <= 1'b0;
		end
	end

	// Burst position
	always_ff @(posedge clk) begin
		if (grant) begin
			beat <= araddr[l2c_pkg::BYTE_W +: l2c_pkg::BEAT_W];
			remain <= arlen;
		end else if (xfer & ~rlast) begin
			// advance only on a real transfer
			beat <= beat + 1'b1;
			remain <= remain - 8'd1;
		end
	end

endmodule

// File: design/l2c_controller.sv
`include "l2c_settings.svh"

module l2c_controller (
	input  logic clk,
	input  logic reset,
	input  logic inst_arvalid,
	input  logic data_arvalid,
	input  logic [`L2C_ADDR_W-1:0] inst_araddr,
	input  logic [`L2C_ADDR_W-1:0] data_araddr,
	input  logic fence,
	input  logic hit,
	input  l2c_pkg::beat_t inst_beat,
	input  l2c_pkg::beat_t data_beat,
	input  logic inst_done,
	input  logic data_done,
	input  logic refill_done,
	output logic [`L2C_ADDR_W-1:0] req_addr,
	output logic inst_grant,
	output logic data_grant,
	output logic refill_start,
	output logic allocate,
	output logic fence_clear,
	output l2c_pkg::beat_t read_beat
);

	l2c_pkg::l2c_state_e state;
	l2c_pkg::l2c_state_e state_next;
	logic fence_pend;
	logic sel_inst;
	logic in_check;

	assign in_check = (state == l2c_pkg::state_check_tag);

	// Next state
	always_comb begin
		state_next = state;
		case (state)
			l2c_pkg::state_free: begin
				// Pending fence wins over any new read
				if (fence_pend | fence)
					state_next = l2c_pkg::state_fence;
				else if (inst_arvalid | data_arvalid)
					state_next = l2c_pkg::state_check_tag;
			end
			l2c_pkg::state_check_tag: begin
				if (!hit)
					state_next = l2c_pkg::state_refill;
				else if (sel_inst)
					state_next = l2c_pkg::state_resp_inst;
				else
					state_next = l2c_pkg::state_resp_data;
			end
			// Look the tag up again once the line is in
			l2c_pkg::state_refill: begin
				if (refill_done)
					state_next = l2c_pkg::state_check_tag;
			end
			l2c_pkg::state_resp_inst: begin
				if (inst_done)
					state_next = l2c_pkg::state_free;
			end
			l2c_pkg::state_resp_data: begin
				if (data_done)
					state_next = l2c_pkg::state_free;
			end
			default: begin
				state_next = l2c_pkg::state_free;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= l2c_pkg::state_free;
			fence_pend <= 1'b0;
		end else begin
			state <= state_next;
			// Held until the fence state has run
			fence_pend <= fence | (fence_pend & (state != l2c_pkg::state_fence));
		end
	end

	// Request capture, instruction port first
	always_ff @(posedge clk) begin
		if (state == l2c_pkg::state_free && state_next == l2c_pkg::state_check_tag) begin
			req_addr <= inst_arvalid ? inst_araddr : data_araddr;
			sel_inst <= inst_arvalid;
		end
	end

	// One cycle pulses out of check-tag
	assign inst_grant = in_check & hit & sel_inst;
	assign data_grant = in_check & hit & ~sel_inst;
	assign allocate = in_check & ~hit;
	assign refill_start = in_check & ~hit;
	assign fence_clear = (state == l2c_pkg::state_fence);

	// Only the responding port drives the read index
	assign read_beat = (state == l2c_pkg::state_resp_data) ? data_beat : inst_beat;

endmodule

// File: design/l2c_top.sv
`include "l2c_settings.svh"

module l2c_top (
	input  logic clk,
	input  logic reset,

	// Instruction client
	input  logic inst_arvalid,
	input  logic [`L2C_ADDR_W-1:0] inst_araddr,
	input  logic [7:0] inst_arlen,
	output logic inst_arready,
	output logic inst_rvalid,
	output logic [`L2C_DATA_W-1:0] inst_rdata,
	output logic inst_rlast,
	input  logic inst_rready,

	// Data client
	input  logic data_arvalid,
	input  logic [`L2C_ADDR_W-1:0] data_araddr,
	input  logic [7:0] data_arlen,
	output logic data_arready,
	output logic data_rvalid,
	output logic [`L2C_DATA_W-1:0] data_rdata,
	output logic data_rlast,
	input  logic data_rready,

	// Next level memory, read only
	output logic mem_arvalid,
	output logic [`L2C_ADDR_W-1:0] mem_araddr,
	output logic [7:0] mem_arlen,
	input  logic mem_arready,
	input  logic mem_rvalid,
	input  logic [`L2C_DATA_W-1:0] mem_rdata,
	input  logic mem_rlast,
	output logic mem_rready,

	input  logic fence
);

	// Latched request and control pulses
	logic [`L2C_ADDR_W-1:0] req_addr;
	logic inst_grant;
	logic data_grant;
	logic refill_start;
	logic allocate;
	logic fence_clear;
	logic refill_done;
	logic inst_done;
	logic data_done;

	// Lookup result, also the fill way during refill
	logic hit;
	l2c_pkg::way_mask_t hit_way;

	// Data store access
	l2c_pkg::beat_t inst_beat;
	l2c_pkg::beat_t data_beat;
	l2c_pkg::beat_t read_beat;
	logic [`L2C_DATA_W-1:0] read_data;
	logic fill_en;
	l2c_pkg::beat_t fill_beat;
	logic [`L2C_DATA_W-1:0] fill_data;

	l2c_controller controller (
		.clk(clk),
		.reset(reset),
		.inst_arvalid(inst_arvalid),
		.data_arvalid(data_arvalid),
		.inst_araddr(inst_araddr),
		.data_araddr(data_araddr),
		.fence(fence),
		.hit(hit),
		.inst_beat(inst_beat),
		.data_beat(data_beat),
		.inst_done(inst_done),
		.data_done(data_done),
		.refill_done(refill_done),
		.req_addr(req_addr),
		.inst_grant(inst_grant),
		.data_grant(data_grant),
		.refill_start(refill_start),
		.allocate(allocate),
		.fence_clear(fence_clear),
		.read_beat(read_beat)
	);

	l1_read_port inst_port (
		.clk(clk),
		.reset(reset),
		.grant(inst_grant),
		.arvalid(inst_arvalid),
		.araddr(inst_araddr),
		.arlen(inst_arlen),
		.rready(inst_rready),
		.read_data(read_data),
		.arready(inst_arready),
		.rvalid(inst_rvalid),
		.rdata(inst_rdata),
		.rlast(inst_rlast),
		.beat(inst_beat),
		.done(inst_done)
	);

	l1_read_port data_port (
		.clk(clk),
		.reset(reset),
		.grant(data_grant),
		.arvalid(data_arvalid),
		.araddr(data_araddr),
		.arlen(data_arlen),
		.rready(data_rready),
		.read_data(read_data),
		.arready(data_arready),
		.rvalid(data_rvalid),
		.rdata(data_rdata),
		.rlast(data_rlast),
		.beat(data_beat),
		.done(data_done)
	);

	tag_store tags (
		.clk(clk),
		.reset(reset),
		.req_addr(req_addr),
		.allocate(allocate),
		.fence_clear(fence_clear),
		.hit(hit),
		.hit_way(hit_way)
	);

	// Set index comes straight from the latched request
	data_store lines (
		.clk(clk),
		.set(req_addr[l2c_pkg::OFFSET_W +: l2c_pkg::SET_W]),
		.way(hit_way),
		.fill_en(fill_en),
		.fill_beat(fill_beat),
		.read_beat(read_beat),
		.fill_data(fill_data),
		.read_data(read_data)
	);

	mem_refill refill (
		.clk(clk),
		.reset(reset),
		.start(refill_start),
		.req_addr(req_addr),
		.mem_arready(mem_arready),
		.mem_rvalid(mem_rvalid),
		.mem_rdata(mem_rdata),
		.mem_rlast(mem_rlast),
		.mem_arvalid(mem_arvalid),
		.mem_araddr(mem_araddr),
		.mem_arlen(mem_arlen),
		.mem_rready(mem_rready),
		.fill_en(fill_en),
		.fill_beat(fill_beat),
		.fill_data(fill_data),
		.done(refill_done)
	);

endmodule

// File: tests/mem_model.sv
`include "l2c_settings.svh"

module mem_model (
	input  logic clk,
	input  logic reset,
	// High holds off the address accept and the next beat
	input  logic stall,
	input  logic arvalid,
	input  logic [`L2C_ADDR_W-1:0] araddr,
	input  logic [7:0] arlen,
	output logic arready,
	output logic rvalid,
	output logic [`L2C_DATA_W-1:0] rdata,
	output logic rlast,
	input  logic rready,
	output int req_count
);

	logic busy;
	logic [`L2C_ADDR_W-1:0] base;
	logic [7:0] len;
	logic [7:0] idx;

	// Upper half is the byte address, lower half its inverse
	function automatic logic [`L2C_DATA_W-1:0] beat_data(input logic [`L2C_ADDR_W-1:0] a);
		return {a, ~a};
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
			rdata <= '0;
			busy <= 1'b0;
			idx <= '0;
			req_count <= 0;
		end else if (!busy) begin
			if (arvalid && arready) begin
				// Address taken, start the burst
				arready <= 1'b0;
				busy <= 1'b1;
				base <= araddr;
				len <= arlen;
				idx <= '0;
				req_count <= req_count + 1;
			end else if (arvalid && !stall) begin
				arready <= 1'b1;
			end
		end else if (rvalid && rready && rlast) begin
			rvalid <= 1'b0;
			rlast <= 1'b0;
			busy <= 1'b0;
		end else if (!rvalid || rready) begin
			// Beat slot is free, either fill it or leave a gap
			if (stall) begin
				rvalid <= 1'b0;
			end else begin
				rvalid <= 1'b1;
				rdata <= beat_data(base + idx * (`L2C_DATA_W / 8));
				rlast <= (idx == len);
				idx <= idx + 8'd1;
			end
		end
	end

endmodule

// File: tests/l2c_tb.sv
`include "l2c_settings.svh"

module l2c_tb;

	localparam int RESET_CYCLES = 10;
	localparam int NUM_ROWS = 17;
	// Worst case row is two misses with stalls and back-pressure
	localparam int ROW_BUDGET = 400;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_ROWS * ROW_BUDGET;
	localparam logic [31:0] SEED = 32'h6735d35d;

	localparam int PORT_INST = 0;
	localparam int PORT_DATA = 1;
	localparam int PORT_BOTH = 2;
	// Memory request expectation per row
	localparam int MEM_NONE = 0;
	localparam int MEM_ONE = 1;
	localparam int MEM_ANY = 2;

	logic clk = 1'b0;
	logic reset;
	logic fence;

	logic inst_arvalid;
	logic [`L2C_ADDR_W-1:0] inst_araddr;
	logic [7:0] inst_arlen;
	logic inst_arready;
	logic inst_rvalid;
	logic [`L2C_DATA_W-1:0] inst_rdata;
	logic inst_rlast;
	logic inst_rready;

	logic data_arvalid;
	logic [`L2C_ADDR_W-1:0] data_araddr;
	logic [7:0] data_arlen;
	logic data_arready;
	logic data_rvalid;
	logic [`L2C_DATA_W-1:0] data_rdata;
	logic data_rlast;
	logic data_rready;

	logic mem_arvalid;
	logic [`L2C_ADDR_W-1:0] mem_araddr;
	logic [7:0] mem_arlen;
	logic mem_arready;
	logic mem_rvalid;
	logic [`L2C_DATA_W-1:0] mem_rdata;
	logic mem_rlast;
	logic mem_rready;
	logic mem_stall;
	int mem_requests;

	// Stimulus table columns
	int row_port [NUM_ROWS];
	logic [`L2C_ADDR_W-1:0] row_addr [NUM_ROWS];
	logic [7:0] row_len [NUM_ROWS];
	logic row_fence [NUM_ROWS];
	int row_expect [NUM_ROWS];
	logic row_bp [NUM_ROWS];

	int cycle = 0;
	int accept_cycle [2];
	int mismatch_errors = 0;
	int other_errors = 0;
	int evict_requests = 0;
	int count_before;
	logic [31:0] rready_state [2];
	logic [31:0] stall_state = SEED;

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	l2c_top UUT (
		.clk(clk),
		.reset(reset),
		.inst_arvalid(inst_arvalid),
		.inst_araddr(inst_araddr),
		.inst_arlen(inst_arlen),
		.inst_arready(inst_arready),
		.inst_rvalid(inst_rvalid),
		.inst_rdata(inst_rdata),
		.inst_rlast(inst_rlast),
		.inst_rready(inst_rready),
		.data_arvalid(data_arvalid),
		.data_araddr(data_araddr),
		.data_arlen(data_arlen),
		.data_arready(data_arready),
		.data_rvalid(data_rvalid),
		.data_rdata(data_rdata),
		.data_rlast(data_rlast),
		.data_rready(data_rready),
		.mem_arvalid(mem_arvalid),
		.mem_araddr(mem_araddr),
		.mem_arlen(mem_arlen),
		.mem_arready(mem_arready),
		.mem_rvalid(mem_rvalid),
		.mem_rdata(mem_rdata),
		.mem_rlast(mem_rlast),
		.mem_rready(mem_rready),
		.fence(fence)
	);

	mem_model memory (
		.clk(clk),
		.reset(reset),
		.stall(mem_stall),
		.arvalid(mem_arvalid),
		.araddr(mem_araddr),
		.arlen(mem_arlen),
		.arready(mem_arready),
		.rvalid(mem_rvalid),
		.rdata(mem_rdata),
		.rlast(mem_rlast),
		.rready(mem_rready),
		.req_count(mem_requests)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Memory side stalls, roughly one cycle in four
	always @(posedge clk) begin
		stall_state = lcg_next(stall_state);
		mem_stall <= (stall_state[31:30] == 2'b00);
	end

	// Reference beat, independent of the memory model
	function automatic logic [`L2C_DATA_W-1:0] expected_beat(input logic [`L2C_ADDR_W-1:0] a);
		return {a, ~a};
	endfunction

	// Client back-pressure, random only on rows that ask for it
	function automatic logic next_ready(input int port, input logic bp);
		rready_state[port] = lcg_next(rready_state[port]);
		return !bp || !rready_state[port][31];
	endfunction

	task automatic add_row(input int idx, input int port, input logic [`L2C_ADDR_W-1:0] addr,
			input logic [7:0] len, input logic fnc, input int exp_mem, input logic bp);
		row_port[idx] = port;
		row_addr[idx] = addr;
		row_len[idx] = len;
		row_fence[idx] = fnc;
		row_expect[idx] = exp_mem;
		row_bp[idx] = bp;
	endtask

	task automatic load_table();
		// First fill, repeat from the other port, partial repeat
		add_row(0, PORT_INST, 32'h0000_1000, 8'd15, 1'b0, MEM_ONE, 1'b0);
		add_row(1, PORT_DATA, 32'h0000_1000, 8'd15, 1'b0, MEM_NONE, 1'b0);
		add_row(2, PORT_INST, 32'h0000_1040, 8'd3, 1'b0, MEM_NONE, 1'b1);
		add_row(3, PORT_DATA, 32'h0000_23a0, 8'd7, 1'b0, MEM_ONE, 1'b1);
		// Fence drops the line filled by row 0
		add_row(4, PORT_INST, 32'h0000_1000, 8'd15, 1'b1, MEM_ONE, 1'b0);
		// Both ports in the same cycle
		add_row(5, PORT_BOTH, 32'h0000_3100, 8'd15, 1'b0, MEM_ONE, 1'b1);
		add_row(6, PORT_BOTH, 32'h0000_3140, 8'd7, 1'b0, MEM_NONE, 1'b0);
		// Five tags in set 5, one more than the ways
		add_row(7, PORT_INST, 32'h0001_0280, 8'd15, 1'b0, MEM_ONE, 1'b0);
		add_row(8, PORT_DATA, 32'h0002_0280, 8'd15, 1'b0, MEM_ONE, 1'b1);
		add_row(9, PORT_INST, 32'h0003_0280, 8'd15, 1'b0, MEM_ONE, 1'b1);
		add_row(10, PORT_DATA, 32'h0004_0280, 8'd15, 1'b0, MEM_ONE, 1'b0);
		add_row(11, PORT_INST, 32'h0005_0280, 8'd15, 1'b0, MEM_ONE, 1'b1);
		add_row(12, PORT_DATA, 32'h0001_0280, 8'd15, 1'b0, MEM_ANY, 1'b0);
		add_row(13, PORT_INST, 32'h0002_0280, 8'd15, 1'b0, MEM_ANY, 1'b1);
		add_row(14, PORT_DATA, 32'h0003_0280, 8'd15, 1'b0, MEM_ANY, 1'b0);
		add_row(15, PORT_INST, 32'h0004_0280, 8'd15, 1'b0, MEM_ANY, 1'b1);
		add_row(16, PORT_DATA, 32'h0005_0280, 8'd15, 1'b0, MEM_ANY, 1'b0);
	endtask

	task automatic drive_request(input int port, input logic valid,
			input logic [`L2C_ADDR_W-1:0] addr, input logic [7:0] len);
		if (port == PORT_INST) begin
			inst_arvalid <= valid;
			inst_araddr <= addr;
			inst_arlen <= len;
		end else begin
			data_arvalid <= valid;
			data_araddr <= addr;
			data_arlen <= len;
		end
	endtask

	task automatic drive_rready(input int port, input logic value);
		if (port == PORT_INST)
			inst_rready <= value;
		else
			data_rready <= value;
	endtask

	task automatic pulse_fence();
		fence <= 1'b1;
		@(posedge clk);
		fence <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	// One client burst, every transferred beat checked
	task automatic read_burst(input int port, input logic [`L2C_ADDR_W-1:0] addr,
			input logic [7:0] len, input logic bp);
		logic accepted;
		logic got_valid;
		logic got_ready;
		logic got_last;
		logic want_last;
		logic [`L2C_DATA_W-1:0] got_data;
		logic [`L2C_DATA_W-1:0] want_data;
		int n;
		string name;
		name = (port == PORT_INST) ? "inst" : "data";
		accepted = 1'b0;
		n = 0;
		drive_request(port, 1'b1, addr, len);
		while (!accepted) begin
			@(posedge clk);
			accepted = (port == PORT_INST) ? inst_arready : data_arready;
		end
		accept_cycle[port] = cycle;
		drive_request(port, 1'b0, '0, '0);
		drive_rready(port, next_ready(port, bp));
		while (n <= len) begin
			@(posedge clk);
			got_valid = (port == PORT_INST) ? inst_rvalid : data_rvalid;
			got_ready = (port == PORT_INST) ? inst_rready : data_rready;
			got_last = (port == PORT_INST) ? inst_rlast : data_rlast;
			got_data = (port == PORT_INST) ? inst_rdata : data_rdata;
			if (got_valid && got_ready) begin
				want_data = expected_beat(addr + n * (`L2C_DATA_W / 8));
				want_last = (n == len);
				if (got_data !== want_data) begin
					mismatch_errors++;
					$display("mismatch %s_rdata beat %0d: got %h expected %h",
						name, n, got_data, want_data);
				end
				if (got_last !== want_last) begin
					mismatch_errors++;
					$display("mismatch %s_rlast beat %0d: got %h expected %h",
						name, n, got_last, want_last);
				end
				n++;
			end
			drive_rready(port, next_ready(port, bp));
		end
		drive_rready(port, 1'b0);
	endtask

	task automatic check_requests(input int row, input int count);
		if (row_expect[row] == MEM_NONE && count != 0) begin
			other_errors++;
			$display("row %0d: cached line caused %0d memory requests", row, count);
		end
		if (row_expect[row] == MEM_ONE && count != 1) begin
			other_errors++;
			$display("row %0d: expected one memory request, saw %0d", row, count);
		end
		if (row_expect[row] == MEM_ANY)
			evict_requests += count;
	endtask

	task automatic print_summary();
		$display("summary: %0d mismatch errors, %0d other errors", mismatch_errors, other_errors);
	endtask

	initial begin
		reset = 1'b1;
		fence = 1'b0;
		inst_arvalid = 1'b0;
		inst_araddr = '0;
		inst_arlen = '0;
		inst_rready = 1'b0;
		data_arvalid = 1'b0;
		data_araddr = '0;
		data_arlen = '0;
		data_rready = 1'b0;
		mem_stall = 1'b0;
		rready_state[PORT_INST] = SEED;
		rready_state[PORT_DATA] = SEED ^ 32'h5a5a_0f0f;
		load_table();
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		for (int r = 0; r < NUM_ROWS; r++) begin
			if (row_fence[r])
				pulse_fence();
			count_before = mem_requests;
			if (row_port[r] == PORT_BOTH) begin
				fork
					read_burst(PORT_INST, row_addr[r], row_len[r], row_bp[r]);
					read_burst(PORT_DATA, row_addr[r], row_len[r], row_bp[r]);
				join
				// Instruction port has fixed priority
				if (accept_cycle[PORT_INST] >= accept_cycle[PORT_DATA]) begin
					other_errors++;
					$display("row %0d: data port accepted before instruction port", r);
				end
			end else begin
				read_burst(row_port[r], row_addr[r], row_len[r], row_bp[r]);
			end
			@(posedge clk);
			check_requests(r, mem_requests - count_before);
		end
		// Five lines in four ways must evict at least one
		if (evict_requests == 0) begin
			other_errors++;
			$display("rereading five lines of one set made no memory request");
		end
		print_summary();
		if (mismatch_errors == 0 && other_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		print_summary();
		$display("Regression failed");
		$finish;
	end

endmodule

// File: project.f
+incdir+include
design/l2c_pkg.sv
design/data_store.sv
design/tag_store.sv
design/mem_refill.sv
design/l1_read_port.sv
design/l2c_controller.sv
design/l2c_top.sv
tests/mem_model.sv
tests/l2c_tb.sv

// File: Bender.yml
package:
  name: l2c

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/l2c_pkg.sv
      - design/data_store.sv
      - design/tag_store.sv
      - design/mem_refill.sv
      - design/l1_read_port.sv
      - design/l2c_controller.sv
      - design/l2c_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/mem_model.sv
      - tests/l2c_tb.sv
